// File: tcdm_copy_pkg.sv
// block-copy engine package with shared widths and controller state encoding
package tcdm_copy_pkg;

  // data word width
  localparam int unsigned DATA_W = 32;

  // word address width, covers a 4096-word memory
  localparam int unsigned ADDR_W = 12;

  // length field width, at most 255 words per copy
  localparam int unsigned LEN_W = 8;

  // controller states
  typedef enum logic [1:0] {
    CTRL_IDLE  = 2'd0,  // waiting for start
    CTRL_RUN   = 2'd1,  // reads and writes in progress
    CTRL_DRAIN = 2'd2,  // all reads issued, writes finishing
    CTRL_DONE  = 2'd3   // one-cycle completion
  } ctrl_state_e;

endpackage

// File: addr_counter.sv
// word-address generator with remaining-word count, stepped once per grant
module addr_counter
  import tcdm_copy_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear,
  input  logic [ADDR_W-1:0] base,
  input  logic [LEN_W-1:0]  len,
  input  logic              step,
  output logic [ADDR_W-1:0] addr,
  output logic [LEN_W-1:0]  remaining,
  output logic              last
);

  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  remaining_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      remaining_q <= '0;
    end else if (clear) begin
      addr_q      <= base;  // load for a new copy
      remaining_q <= len;
    end else if (step) begin
      addr_q      <= addr_q + 1'b1;
      remaining_q <= remaining_q - 1'b1;
    end
  end

  assign addr      = addr_q;
  assign remaining = remaining_q;

  // high while the current word is the final one
  assign last = (remaining_q == LEN_W'(1));

endmodule

// File: copy_fifo.sv
// read-data buffer that reserves a slot for every read still in flight
module copy_fifo
  import tcdm_copy_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear,
  input  logic              reserve,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              pop,
  output logic [DATA_W-1:0] head_data,
  output logic              not_empty,
  output logic              has_room
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr, rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CNT_W-1:0]  rsv_count;  // granted reads not yet returned

  always_ff @(posedge clk_i) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      rsv_count <= '0;
    end else if (clear) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      rsv_count <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      // arriving data turns a reservation into an occupied slot
      if (reserve && !push)
        rsv_count <= rsv_count + 1'b1;
      else if (push && !reserve)
        rsv_count <= rsv_count - 1'b1;
    end
  end

  assign head_data = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign has_room  = (count + rsv_count) < FIFO_DEPTH;

endmodule

// File: copy_ctrl_fsm.sv
// copy controller that sequences a transfer and raises the channel requests
module copy_ctrl_fsm
  import tcdm_copy_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start,
  input  logic [LEN_W-1:0] len,
  input  logic [LEN_W-1:0] rd_remaining,
  input  logic             rd_gnt,
  input  logic             wr_last,
  input  logic             wr_gnt,
  input  logic             buf_room,
  input  logic             buf_not_empty,
  output logic             clear,
  output logic             rd_req,
  output logic             wr_req,
  output logic             busy,
  output logic             done
);

  ctrl_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      state_q <= CTRL_IDLE;
    else
      state_q <= state_d;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (start) begin
          if (len == '0)
            state_d = CTRL_DONE;  // nothing to move
          else
            state_d = CTRL_RUN;
        end
      end
      CTRL_RUN: begin
        if (rd_gnt && rd_remaining == LEN_W'(1))
          state_d = CTRL_DRAIN;  // last read issued
      end
      CTRL_DRAIN: begin
        if (wr_gnt && wr_last)
          state_d = CTRL_DONE;
      end
      CTRL_DONE: begin
        state_d = CTRL_IDLE;
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  // start is only honoured while idle
  assign clear = (state_q == CTRL_IDLE) && start;

  // a read may only go out if its data has a slot to land in
  assign rd_req = (state_q == CTRL_RUN) && (rd_remaining != '0) && buf_room;

  assign wr_req = ((state_q == CTRL_RUN) || (state_q == CTRL_DRAIN)) && buf_not_empty;

  assign busy = (state_q == CTRL_RUN) || (state_q == CTRL_DRAIN);
  assign done = (state_q == CTRL_DONE);  // one cycle by construction

endmodule

// File: tcdm_mux_dynamic.sv
// round-robin funnel of TCDM virtual channels onto fewer initiator ports
module tcdm_mux_dynamic
  import tcdm_copy_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 2,
  parameter int unsigned NB_OUT_CHAN = 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  clear,

  input  logic [NB_IN_CHAN-1:0]                 in_req,
  input  logic [NB_IN_CHAN-1:0][ADDR_W-1:0]     in_addr,
  input  logic [NB_IN_CHAN-1:0]                 in_wen,
  input  logic [NB_IN_CHAN-1:0][DATA_W-1:0]     in_wdata,
  output logic [NB_IN_CHAN-1:0]                 in_gnt,
  output logic [NB_IN_CHAN-1:0]                 in_rvalid,
  output logic [NB_IN_CHAN-1:0][DATA_W-1:0]     in_rdata,

  output logic [NB_OUT_CHAN-1:0]                out_req,
  output logic [NB_OUT_CHAN-1:0][ADDR_W-1:0]    out_addr,
  output logic [NB_OUT_CHAN-1:0]                out_wen,
  output logic [NB_OUT_CHAN-1:0][DATA_W-1:0]    out_wdata,
  input  logic [NB_OUT_CHAN-1:0]                out_gnt,
  input  logic [NB_OUT_CHAN-1:0]                out_rvalid,
  input  logic [NB_OUT_CHAN-1:0][DATA_W-1:0]    out_rdata
);

  // channels competing for each output port
  localparam int unsigned GRP   = NB_IN_CHAN / NB_OUT_CHAN;
  localparam int unsigned CNT_W = (GRP > 1) ? $clog2(GRP) : 1;

  logic [CNT_W-1:0]                   rr_counter;
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]  winner_d;
  logic [NB_OUT_CHAN-1:0][CNT_W-1:0]  winner_q;
  logic [NB_OUT_CHAN-1:0]             out_req_q;
  logic [NB_OUT_CHAN-1:0]             wait_q;  // port requested last cycle without grant
  logic                               rr_step;

  assign rr_step = |(out_req & out_gnt);  // any port transferred

  // rotating counter shared by all ports
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear) begin
      rr_counter <= '0;
    end else if (rr_step) begin
      if (rr_counter == CNT_W'(GRP - 1))
        rr_counter <= '0;
      else
        rr_counter <= rr_counter + 1'b1;
    end
  end

  // port i serves channels i, i+NB_OUT_CHAN, i+2*NB_OUT_CHAN ...
  always_comb begin
    out_req = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned j = 0; j < GRP; j++)
        out_req[i] = out_req[i] | in_req[j*NB_OUT_CHAN+i];
    end
  end

  // last requester in rotated order wins
  always_comb begin
    int unsigned idx;
    winner_d = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      winner_d[i] = rr_counter;  // idle default
      for (int unsigned jj = 0; jj < GRP; jj++) begin
        idx = rr_counter + jj;
        if (idx >= GRP)
          idx = idx - GRP;  // wrap within group
        if (in_req[idx*NB_OUT_CHAN+i])
          winner_d[i] = CNT_W'(idx);
      end
      if (wait_q[i])
        winner_d[i] = winner_q[i];  // stalled request stays on its channel
    end
  end

  always_comb begin
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      out_addr[i]  = in_addr[winner_d[i]*NB_OUT_CHAN+i];
      out_wen[i]   = in_wen[winner_d[i]*NB_OUT_CHAN+i];
      out_wdata[i] = in_wdata[winner_d[i]*NB_OUT_CHAN+i];
    end
  end

  // remember who owns the response of the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q  <= '0;
      out_req_q <= '0;
      wait_q    <= '0;
    end else if (clear) begin
      winner_q  <= '0;
      out_req_q <= '0;
      wait_q    <= '0;
    end else begin
      winner_q  <= winner_d;
      out_req_q <= out_req;
      wait_q    <= out_req & ~out_gnt;
    end
  end

  always_comb begin
    in_gnt    = '0;
    in_rvalid = '0;
    in_rdata  = '0;
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      // grant only reaches a channel that actually requests
      in_gnt[winner_d[i]*NB_OUT_CHAN+i]    = out_gnt[i] & out_req[i];
      in_rvalid[winner_q[i]*NB_OUT_CHAN+i] = out_rvalid[i] & out_req_q[i];
      in_rdata[winner_q[i]*NB_OUT_CHAN+i]  = out_rdata[i];
    end
  end

endmodule

// File: tcdm_copy_top.sv
// block-copy engine top with a read and a write channel sharing one TCDM port
module tcdm_copy_top
  import tcdm_copy_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 2,
  parameter int unsigned NB_OUT_CHAN = 1,
  parameter int unsigned FIFO_DEPTH  = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // host side
  input  logic                               start,
  input  logic [ADDR_W-1:0]                  src_addr,
  input  logic [ADDR_W-1:0]                  dst_addr,
  input  logic [LEN_W-1:0]                   len,
  output logic                               busy,
  output logic                               done,

  // memory side
  output logic [NB_OUT_CHAN-1:0]             mem_req,
  output logic [NB_OUT_CHAN-1:0][ADDR_W-1:0] mem_addr,
  output logic [NB_OUT_CHAN-1:0]             mem_wen,
  output logic [NB_OUT_CHAN-1:0][DATA_W-1:0] mem_wdata,
  input  logic [NB_OUT_CHAN-1:0]             mem_gnt,
  input  logic [NB_OUT_CHAN-1:0]             mem_rvalid,
  input  logic [NB_OUT_CHAN-1:0][DATA_W-1:0] mem_rdata
);

  localparam int unsigned RD_CH = 0;
  localparam int unsigned WR_CH = 1;

  logic [NB_IN_CHAN-1:0]             ch_req;
  logic [NB_IN_CHAN-1:0][ADDR_W-1:0] ch_addr;
  logic [NB_IN_CHAN-1:0]             ch_wen;
  logic [NB_IN_CHAN-1:0][DATA_W-1:0] ch_wdata;
  logic [NB_IN_CHAN-1:0]             ch_gnt;
  logic [NB_IN_CHAN-1:0]             ch_rvalid;
  logic [NB_IN_CHAN-1:0][DATA_W-1:0] ch_rdata;

  logic              clear;
  logic              rd_req, wr_req;
  logic [ADDR_W-1:0] rd_addr, wr_addr;
  logic [LEN_W-1:0]  rd_remaining;
  logic              wr_last;
  logic [DATA_W-1:0] head_data;
  logic              buf_not_empty, buf_room;

  assign ch_req[RD_CH]   = rd_req;
  assign ch_req[WR_CH]   = wr_req;
  assign ch_addr[RD_CH]  = rd_addr;
  assign ch_addr[WR_CH]  = wr_addr;
  assign ch_wen[RD_CH]   = 1'b1;  // read
  assign ch_wen[WR_CH]   = 1'b0;  // write
  assign ch_wdata[RD_CH] = '0;
  assign ch_wdata[WR_CH] = head_data;

  copy_ctrl_fsm i_ctrl (
    .clk_i,
    .rst_ni,
    .start,
    .len,
    .rd_remaining,
    .rd_gnt        (ch_gnt[RD_CH]),
    .wr_last,
    .wr_gnt        (ch_gnt[WR_CH]),
    .buf_room,
    .buf_not_empty,
    .clear,
    .rd_req,
    .wr_req,
    .busy,
    .done
  );

  addr_counter i_rd_cnt (
    .clk_i,
    .rst_ni,
    .clear,
    .base      (src_addr),
    .len,
    .step      (ch_gnt[RD_CH]),
    .addr      (rd_addr),
    .remaining (rd_remaining),
    .last      ()
  );

  addr_counter i_wr_cnt (
    .clk_i,
    .rst_ni,
    .clear,
    .base      (dst_addr),
    .len,
    .step      (ch_gnt[WR_CH]),
    .addr      (wr_addr),
    .remaining (),
    .last      (wr_last)
  );

  copy_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk_i,
    .rst_ni,
    .clear,
    .reserve   (ch_gnt[RD_CH]),     // slot held from grant to response
    .push      (ch_rvalid[RD_CH]),
    .push_data (ch_rdata[RD_CH]),
    .pop       (ch_gnt[WR_CH]),
    .head_data,
    .not_empty (buf_not_empty),
    .has_room  (buf_room)
  );

  tcdm_mux_dynamic #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_mux (
    .clk_i,
    .rst_ni,
    .clear,
    .in_req     (ch_req),
    .in_addr    (ch_addr),
    .in_wen     (ch_wen),
    .in_wdata   (ch_wdata),
    .in_gnt     (ch_gnt),
    .in_rvalid  (ch_rvalid),
    .in_rdata   (ch_rdata),
    .out_req    (mem_req),
    .out_addr   (mem_addr),
    .out_wen    (mem_wen),
    .out_wdata  (mem_wdata),
    .out_gnt    (mem_gnt),
    .out_rvalid (mem_rvalid),
    .out_rdata  (mem_rdata)
  );

endmodule

// File: tcdm_copy_assertions.sv
// concurrent checks on the TCDM mux request, grant and response routing
module tcdm_copy_assertions
  import tcdm_copy_pkg::*;
#(
  parameter int unsigned NB_IN_CHAN  = 2,
  parameter int unsigned NB_OUT_CHAN = 1
) (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic [NB_IN_CHAN-1:0]              in_req,
  input logic [NB_IN_CHAN-1:0][ADDR_W-1:0]  in_addr,
  input logic [NB_IN_CHAN-1:0]              in_wen,
  input logic [NB_IN_CHAN-1:0][DATA_W-1:0]  in_wdata,
  input logic [NB_IN_CHAN-1:0]              in_gnt,
  input logic [NB_IN_CHAN-1:0]              in_rvalid,
  input logic [NB_OUT_CHAN-1:0]             out_req,
  input logic [NB_OUT_CHAN-1:0][ADDR_W-1:0] out_addr,
  input logic [NB_OUT_CHAN-1:0]             out_wen,
  input logic [NB_OUT_CHAN-1:0][DATA_W-1:0] out_wdata,
  input logic [NB_OUT_CHAN-1:0]             out_gnt
);

  localparam int unsigned GRP = NB_IN_CHAN / NB_OUT_CHAN;

  logic [NB_OUT_CHAN-1:0][GRP-1:0] grp_gnt;  // grants regrouped per port

  always_comb begin
    for (int unsigned i = 0; i < NB_OUT_CHAN; i++) begin
      for (int unsigned j = 0; j < GRP; j++)
        grp_gnt[i][j] = in_gnt[j*NB_OUT_CHAN+i];
    end
  end

  for (genvar i = 0; i < NB_OUT_CHAN; i++) begin : g_port
    // a stalled port request keeps its whole transfer
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_req[i] && !out_gnt[i] |=> out_req[i] && $stable(out_addr[i])
                                    && $stable(out_wen[i]) && $stable(out_wdata[i]))
      else $error("output request changed before grant");
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $countones(grp_gnt[i]) <= 1)
      else $error("more than one channel granted on one port");
  end

  for (genvar k = 0; k < NB_IN_CHAN; k++) begin : g_chan
    // a waiting channel keeps its whole request
    a_fields_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_req[k] && !in_gnt[k] |=> in_req[k] && $stable(in_addr[k]) && $stable(in_wen[k])
                                  && $stable(in_wdata[k]))
      else $error("channel request changed while waiting for grant");
    a_rvalid_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_rvalid[k] |-> $past(in_gnt[k] && in_wen[k]))
      else $error("response routed to a channel without a read grant");
  end

endmodule

bind tcdm_mux_dynamic tcdm_copy_assertions #(
  .NB_IN_CHAN  (NB_IN_CHAN),
  .NB_OUT_CHAN (NB_OUT_CHAN)
) i_mux_assertions (
  .clk_i, .rst_ni, .in_req, .in_addr, .in_wen, .in_wdata, .in_gnt, .in_rvalid,
  .out_req, .out_addr, .out_wen, .out_wdata, .out_gnt
);

// File: tb_tcdm_copy.sv
// directed testbench for the block-copy engine, with a TCDM memory model on its port
module tb_tcdm_copy
  import tcdm_copy_pkg::*;
();

  localparam int TOTAL_WORDS     = 8 + 40 + 0 + 1 + 12 + 12;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 400;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          start;
  logic [ADDR_W-1:0]             src_addr, dst_addr;
  logic [LEN_W-1:0]              len;
  logic                          busy, done;
  logic [0:0]                    mem_req, mem_wen, mem_gnt, mem_rvalid;
  logic [0:0][ADDR_W-1:0]        mem_addr;
  logic [0:0][DATA_W-1:0]        mem_wdata, mem_rdata;

  logic [DATA_W-1:0] mem [4096];
  integer            seed = 32'hc7be_43e6;
  bit                stall_en, gnt_now;
  bit                pend_valid;
  int                pend_addr, wa;
  int                cur_dst, cur_len;
  int                rd_grants, wr_grants, bad_writes, done_seen, req_seen;
  int                errors, err_mark, tests_run, tests_failed;

  tcdm_copy_top #(
    .NB_IN_CHAN  (2),
    .NB_OUT_CHAN (1),
    .FIFO_DEPTH  (4)
  ) i_dut (
    .clk_i, .rst_ni, .start, .src_addr, .dst_addr, .len, .busy, .done,
    .mem_req, .mem_addr, .mem_wen, .mem_wdata, .mem_gnt, .mem_rvalid, .mem_rdata
  );

  always #2 clk_i = ~clk_i;

  // reads answer one cycle after grant, writes land on grant
  always @(negedge clk_i) begin
    mem_rvalid <= pend_valid;
    mem_rdata  <= pend_valid ? mem[pend_addr] : '0;
    pend_valid = 1'b0;
    gnt_now    = stall_en ? (($random(seed) & 1) != 0) : 1'b1;
    mem_gnt   <= gnt_now;
    if (done) done_seen++;
    if (mem_req[0]) req_seen++;
    if (mem_req[0] && gnt_now) begin
      wa = int'(mem_addr[0]);
      if (mem_wen[0]) begin
        rd_grants++;
        pend_valid = 1'b1;
        pend_addr  = wa;
      end else begin
        wr_grants++;
        mem[wa] = mem_wdata[0];
        if (wa < cur_dst || wa >= cur_dst + cur_len) bad_writes++;  // stray write
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 4);
    $display("watchdog expired, the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [DATA_W-1:0] fill_word(input int a);
    return 32'hf0f0_0000 ^ 32'(a);
  endfunction

  // tag, copy index and source address packed into one word
  function automatic logic [DATA_W-1:0] src_word(input logic [7:0] tag, input int base,
                                                 input int idx);
    return {tag, 4'h5, 8'(idx), 12'(base + idx)};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error @%0t: %s expected %h, got %h", $time, what, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic preload(input int src, input int n, input logic [7:0] tag);
    for (int i = 0; i < n; i++)
      mem[src + i] = src_word(tag, src, i);
  endtask

  task automatic check_copy(input int src, input int dst, input int n, input logic [7:0] tag);
    for (int i = 0; i < n; i++) begin
      if (mem[dst + i] !== src_word(tag, src, i))
        report_mismatch($sformatf("mem[%03h]", dst + i), src_word(tag, src, i), mem[dst + i]);
    end
  endtask

  task automatic reset_idle_test();
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_i);
      if (c == 1) rst_ni = 1'b1;  // two reset cycles seen
      if (busy !== 1'b0) report_mismatch("busy", 0, busy);
      if (done !== 1'b0) report_mismatch("done", 0, done);
      if (mem_req !== 1'b0) report_mismatch("mem_req", 0, mem_req);
    end
  endtask

  // poke pulses start again while the copy is running
  task automatic run_copy(input int src, input int dst, input int n, input bit stall,
                          input bit poke);
    int cyc;
    cur_dst    = dst;
    cur_len    = n;
    stall_en   = stall;
    rd_grants  = 0;
    wr_grants  = 0;
    bad_writes = 0;
    done_seen  = 0;
    req_seen   = 0;
    @(negedge clk_i);
    src_addr = ADDR_W'(src);
    dst_addr = ADDR_W'(dst);
    len      = LEN_W'(n);
    start    = 1'b1;
    @(negedge clk_i);
    start = 1'b0;
    if (poke) begin
      repeat (3) @(negedge clk_i);
      src_addr = ADDR_W'(dst);
      dst_addr = ADDR_W'(src);
      len      = LEN_W'(3);
      start    = 1'b1;
      @(negedge clk_i);
      start = 1'b0;
    end
    cyc = 0;
    while (done !== 1'b1 && cyc < n * 20 + 20) begin
      @(negedge clk_i);
      cyc++;
    end
    if (done !== 1'b1) begin
      $display("timeout: no done within %0d cycles for a %0d-word copy", cyc, n);
      errors++;
    end
    repeat (2) @(negedge clk_i);
    if (busy !== 1'b0) report_mismatch("busy", 0, busy);
    if (done_seen != 1) report_mismatch("done pulse cycles", 1, done_seen);
    if (rd_grants != n) report_mismatch("read grants", n, rd_grants);
    if (wr_grants != n) report_mismatch("write grants", n, wr_grants);
    if (bad_writes != 0) report_mismatch("writes outside destination", 0, bad_writes);
    if (n == 0 && req_seen != 0) report_mismatch("mem_req cycles", 0, req_seen);
  endtask

  initial begin
    rst_ni     = 1'b0;
    start      = 1'b0;
    src_addr   = '0;
    dst_addr   = '0;
    len        = '0;
    mem_gnt    = '0;
    mem_rvalid = '0;
    mem_rdata  = '0;
    for (int a = 0; a < 4096; a++)
      mem[a] = fill_word(a);
    reset_idle_test();
    finish_test("reset_idle");
    preload('h100, 8, 8'h11);
    run_copy('h100, 'h200, 8, 1'b0, 1'b0);
    check_copy('h100, 'h200, 8, 8'h11);
    finish_test("copy_8");
    preload('h300, 40, 8'h22);
    run_copy('h300, 'h400, 40, 1'b1, 1'b0);
    check_copy('h300, 'h400, 40, 8'h22);
    finish_test("stall_40");
    run_copy('h500, 'h600, 0, 1'b0, 1'b0);
    if (mem['h600] !== fill_word('h600)) report_mismatch("mem[600]", fill_word('h600), mem['h600]);
    preload('h700, 1, 8'h33);
    run_copy('h700, 'h780, 1, 1'b1, 1'b0);
    check_copy('h700, 'h780, 1, 8'h33);
    if (mem['h781] !== fill_word('h781)) report_mismatch("mem[781]", fill_word('h781), mem['h781]);
    finish_test("len_0_1");
    preload('h800, 12, 8'h44);
    run_copy('h800, 'h900, 12, 1'b1, 1'b0);
    preload('ha00, 12, 8'h55);
    run_copy('ha00, 'hb00, 12, 1'b1, 1'b1);
    check_copy('h800, 'h900, 12, 8'h44);
    check_copy('ha00, 'hb00, 12, 8'h55);
    finish_test("back_to_back");
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: files.f
tcdm_copy_pkg.sv
addr_counter.sv
copy_fifo.sv
copy_ctrl_fsm.sv
tcdm_mux_dynamic.sv
tcdm_copy_top.sv
tcdm_copy_assertions.sv
tb_tcdm_copy.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module tb_tcdm_copy -o tb_tcdm_copy

./obj_dir/tb_tcdm_copy | tee sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
